//--- tsPkg.sv
`default_nettype none

package tsPkg;

   //////////////////////////////
   // transport packet framing
   //////////////////////////////

   localparam int packetLen = 188;               // bytes per ts packet
   localparam int addrWidth = 8;                 // byte index 0..187

   localparam logic [7:0] syncByte = 8'h47;      // normal sync
   localparam logic [7:0] syncInv  = 8'hB8;      // sync at group start, bitwise not of 0x47

   //////////////////////////////
   // energy dispersal prbs
   //////////////////////////////

   // generator 1 + x^14 + x^15
   // register kept with stage 1 at the msb, stage 15 at the lsb
   localparam logic [14:0] prbsInit = 15'b100101010000000;

   localparam int groupLen = 8;                  // packets per prbs period

   //////////////////////////////
   // output pacing
   //////////////////////////////

   localparam int strobeDiv      = 8;            // clocks per output byte
   localparam int strobeCntWidth = 3;            // divider width, log2 of strobeDiv

endpackage

`default_nettype wire

//--- packetWriter.sv
`timescale 1ns/10ps
`default_nettype none

module packetWriter
(
   input  wire logic                    clk,         // ~56 mhz
   input  wire logic                    reset,       // async, active high
   input  wire logic [7:0]              inByte,      // raw ts byte
   input  wire logic                    inValid,     // qualifies inByte
   output logic                         wrValid,     // byte handed to randomizer
   output logic                         wrFirst,     // this byte is the sync
   output logic [7:0]                   wrByte,      // byte to randomize
   output logic                         wrEn,        // buffer write
   output logic [tsPkg::addrWidth-1:0]  wrAddr,      // byte slot in bank
   output logic                         wrBank,      // bank being filled
   output logic                         packetDone   // one clock, bank complete
);

   import tsPkg::*;

   localparam logic [addrWidth-1:0] lastAddr = addrWidth'(packetLen - 1);

   typedef enum logic {hunt, collect} stateT;

   stateT                state;          // alignment state
   logic [addrWidth-1:0] byteCnt;        // address of next collected byte
   logic                 isSync;         // input matches 0x47
   logic                 accept;         // byte joins the packet
   logic                 lastWritten;    // byte 187 goes into ram this edge

   assign isSync      = (inByte == syncByte);
   assign accept      = inValid && ((state == collect) || isSync); // hunt drops non-sync
   assign lastWritten = wrEn && (wrAddr == lastAddr);

   //////////////////////////////
   // alignment and addressing
   //////////////////////////////

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state      <= hunt;
         byteCnt    <= '0;
         wrValid    <= 1'b0;
         wrFirst    <= 1'b0;
         wrEn       <= 1'b0;
         wrAddr     <= '0;
         wrBank     <= 1'b1;                 // first packet lands in bank 1
         packetDone <= 1'b0;
      end
      else
      begin
         wrValid    <= accept;               // steps the prbs
         wrEn       <= accept;               // writes randByte, same cycle
         wrFirst    <= accept && (state == hunt);
         packetDone <= lastWritten;          // after the final write
         if (lastWritten)
            wrBank <= ~wrBank;               // flip once 187 is stored

         if (accept)
         begin
            if (state == hunt)
            begin
               wrAddr  <= '0;                // sync is byte 0
               byteCnt <= addrWidth'(1);
               state   <= collect;
            end
            else
            begin
               wrAddr <= byteCnt;
               if (byteCnt == lastAddr)
                  state <= hunt;             // re-hunt for next sync
               else
                  byteCnt <= byteCnt + 1'b1;
            end
         end
      end
   end

   // payload stage
   always_ff @(posedge clk)
   begin
      if (accept)
         wrByte <= inByte;
   end

endmodule

`default_nettype wire

//--- energyDispersal.sv
`timescale 1ns/10ps
`default_nettype none

module energyDispersal
(
   input  wire logic       clk,        // ~56 mhz
   input  wire logic       reset,      // async, active high
   input  wire logic [7:0] wrByte,     // byte from writer
   input  wire logic       wrValid,    // byte present, prbs steps
   input  wire logic       wrFirst,    // byte is a sync
   output logic [7:0]      randByte    // scrambled byte, combinational
);

   import tsPkg::*;

   localparam int groupCntWidth = $clog2(groupLen);
   localparam logic [groupCntWidth-1:0] lastGroup = groupCntWidth'(groupLen - 1);

   logic [14:0]              prbs;        // stage 1 msb .. stage 15 lsb
   logic [14:0]              prbsStep8;   // register after eight shifts
   logic [7:0]               prbsBits;    // eight output bits, first in bit 7
   logic [groupCntWidth-1:0] groupCnt;    // packet index inside group of eight
   logic                     groupStart;  // sync of packet 0 in group

   assign groupStart = wrFirst && (groupCnt == '0);

   //////////////////////////////
   // eight prbs steps per byte
   //////////////////////////////

   // out bit = stage 14 xor stage 15, fed back into stage 1
   always_comb
   begin
      prbsStep8 = prbs;
      prbsBits  = '0;
      for (int i = 7; i >= 0; i--)
      begin
         prbsBits[i] = prbsStep8[1] ^ prbsStep8[0];        // stages 14, 15
         prbsStep8   = {prbsBits[i], prbsStep8[14:1]};     // shift toward stage 15
      end
   end

   //////////////////////////////
   // byte mapping
   //////////////////////////////

   always_comb
   begin
      if (groupStart)
         randByte = syncInv;                 // 0x47 -> 0xB8 marks the period
      else if (wrFirst)
         randByte = wrByte;                  // other syncs untouched
      else
         randByte = wrByte ^ prbsBits;       // payload, msb gets first bit
   end

   //////////////////////////////
   // prbs register and group count
   //////////////////////////////

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         prbs     <= prbsInit;
         groupCnt <= '0;                     // first packet opens a group
      end
      else if (wrValid)
      begin
         if (groupStart)
            prbs <= prbsInit;                // restart, first payload byte uses seed
         else
            prbs <= prbsStep8;               // plain syncs still clock 8 steps

         if (wrFirst)
         begin
            if (groupCnt == lastGroup)
               groupCnt <= '0;
            else
               groupCnt <= groupCnt + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- pingPongRam.sv
`timescale 1ns/10ps
`default_nettype none

module pingPongRam
(
   input  wire logic                       clk,      // ~56 mhz
   input  wire logic                       wrEn,     // write strobe
   input  wire logic                       wrBank,   // bank being filled
   input  wire logic [tsPkg::addrWidth-1:0] wrAddr,  // byte in packet
   input  wire logic [7:0]                 wrData,   // scrambled byte
   input  wire logic                       rdBank,   // bank being drained
   input  wire logic [tsPkg::addrWidth-1:0] rdAddr,  // byte in packet
   output logic [7:0]                      rdData    // one clock after rdAddr
);

   import tsPkg::*;

   localparam int memDepth = 2 * packetLen;          // 376 bytes
   localparam int idxWidth = $clog2(memDepth);
   localparam logic [idxWidth-1:0] bankBase = idxWidth'(packetLen);  // bank 1 offset

   logic [7:0]          mem [0:memDepth-1];          // both banks, back to back
   logic [idxWidth-1:0] wrIdx;
   logic [idxWidth-1:0] rdIdx;

   assign wrIdx = wrBank ? bankBase + idxWidth'(wrAddr) : idxWidth'(wrAddr);
   assign rdIdx = rdBank ? bankBase + idxWidth'(rdAddr) : idxWidth'(rdAddr);

   // write port
   always_ff @(posedge clk)
   begin
      if (wrEn)
         mem[wrIdx] <= wrData;
   end

   // read port, registered
   always_ff @(posedge clk)
   begin
      rdData <= mem[rdIdx];
   end

endmodule

`default_nettype wire

//--- outStage.sv
`timescale 1ns/10ps
`default_nettype none

module outStage
(
   input  wire logic                    clk,         // ~56 mhz
   input  wire logic                    reset,       // async, active high
   input  wire logic                    packetDone,  // writer finished a bank
   output logic                         rdBank,      // bank being read
   output logic [tsPkg::addrWidth-1:0]  rdAddr,      // read pointer
   input  wire logic [7:0]              rdData,      // ram data, one clock late
   output logic [7:0]                   outByte,     // output byte
   output logic                         byteStrobe,  // one clock in eight
   output logic                         outValid,    // level, packet on the wire
   output logic                         packetOut    // pulse after the last byte
);

   import tsPkg::*;

   localparam logic [strobeCntWidth-1:0] lastCnt = strobeCntWidth'(strobeDiv - 1);
   localparam logic [addrWidth-1:0] lastAddr = addrWidth'(packetLen - 1);

   logic [strobeCntWidth-1:0] strobeCnt;   // free running divider
   logic                      byteEn;      // internal byte slot enable
   logic                      running;     // packet readout in progress
   logic                      start;       // bank ready, wait for slot
   logic                      endPending;  // last byte out, eop due next slot

   //////////////////////////////
   // byte slot generation
   //////////////////////////////

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         strobeCnt  <= '0;
         byteEn     <= 1'b0;
         byteStrobe <= 1'b0;
      end
      else
      begin
         strobeCnt  <= strobeCnt + 1'b1;           // wraps every 8
         byteEn     <= (strobeCnt == lastCnt);
         byteStrobe <= byteEn;                     // outByte settled by now
      end
   end

   //////////////////////////////
   // readout sequencer
   //////////////////////////////

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         rdBank     <= 1'b0;
         rdAddr     <= '0;
         running    <= 1'b0;
         start      <= 1'b0;
         endPending <= 1'b0;
         outValid   <= 1'b0;
         packetOut  <= 1'b0;
      end
      else
      begin
         packetOut <= 1'b0;                        // single clock pulse
         if (running)
         begin
            if (byteEn)
            begin
               outValid <= 1'b1;
               if (rdAddr == lastAddr)
               begin
                  running    <= 1'b0;              // back to idle
                  endPending <= 1'b1;
               end
               else
                  rdAddr <= rdAddr + 1'b1;         // next byte ready before next slot
            end
         end
         else
         begin
            if (byteEn)
            begin
               outValid   <= 1'b0;                 // gap slot
               packetOut  <= endPending;           // eop one slot after last byte
               endPending <= 1'b0;
            end

            if (packetDone)
            begin
               rdBank <= ~rdBank;                  // now names the bank just written
               rdAddr <= '0;
               start  <= 1'b1;
            end

            if (start && byteEn)
            begin
               running <= 1'b1;                    // rdData holds byte 0 by now
               start   <= 1'b0;
            end
         end
      end
   end

   // byte capture
   always_ff @(posedge clk)
   begin
      if (running && byteEn)
         outByte <= rdData;
   end

endmodule

`default_nettype wire

//--- tsTxTop.sv
`timescale 1ns/10ps
`default_nettype none

module tsTxTop
(
   input  wire logic       clk,         // ~56 mhz
   input  wire logic       reset,       // async, active high
   input  wire logic [7:0] inByte,      // ts byte in
   input  wire logic       inValid,     // inByte qualifier
   output logic [7:0]      outByte,     // scrambled byte out
   output logic            byteStrobe,  // byte slot marker
   output logic            outValid,    // packet level
   output logic            packetOut    // end of packet
);

   import tsPkg::*;

   //////////////////////////////
   // internal nets
   //////////////////////////////

   logic                 wrValid;       // writer -> randomizer
   logic                 wrFirst;
   logic [7:0]           wrByte;
   logic [7:0]           randByte;      // randomizer -> ram data
   logic                 wrEn;          // writer -> ram
   logic [addrWidth-1:0] wrAddr;
   logic                 wrBank;
   logic                 packetDone;    // writer -> output stage
   logic                 rdBank;        // output stage -> ram
   logic [addrWidth-1:0] rdAddr;
   logic [7:0]           rdData;        // ram -> output stage

   packetWriter writer0
   (
      .clk        (clk),
      .reset      (reset),
      .inByte     (inByte),
      .inValid    (inValid),
      .wrValid    (wrValid),
      .wrFirst    (wrFirst),
      .wrByte     (wrByte),
      .wrEn       (wrEn),
      .wrAddr     (wrAddr),
      .wrBank     (wrBank),
      .packetDone (packetDone)
   );

   energyDispersal rand0
   (
      .clk      (clk),
      .reset    (reset),
      .wrByte   (wrByte),
      .wrValid  (wrValid),
      .wrFirst  (wrFirst),
      .randByte (randByte)
   );

   pingPongRam ram0
   (
      .clk    (clk),
      .wrEn   (wrEn),
      .wrBank (wrBank),
      .wrAddr (wrAddr),
      .wrData (randByte),
      .rdBank (rdBank),
      .rdAddr (rdAddr),
      .rdData (rdData)
   );

   outStage out0
   (
      .clk        (clk),
      .reset      (reset),
      .packetDone (packetDone),
      .rdBank     (rdBank),
      .rdAddr     (rdAddr),
      .rdData     (rdData),
      .outByte    (outByte),
      .byteStrobe (byteStrobe),
      .outValid   (outValid),
      .packetOut  (packetOut)
   );

endmodule

`default_nettype wire

//--- tsTxTop_sva.sv
`timescale 1ns/10ps
`default_nettype none

module outStageSva
(
   input wire logic clk,
   input wire logic reset,
   input wire logic packetDone,   // writer handoff
   input wire logic running,      // readout in progress
   input wire logic byteStrobe,
   input wire logic packetOut
);

   // no back-pressure, a new bank must wait for idle
   noDoneWhileRunning: assert property (@(posedge clk) disable iff (reset)
      !(packetDone && running))
      else $error("packetDone arrived while the output stage was reading a bank");

   // one slot in eight, never two in a row
   strobeIsolated: assert property (@(posedge clk) disable iff (reset)
      byteStrobe |=> !byteStrobe)
      else $error("byteStrobe high in two consecutive cycles");

   eopSingleCycle: assert property (@(posedge clk) disable iff (reset)
      packetOut |=> !packetOut)
      else $error("packetOut longer than one cycle");

endmodule

bind outStage outStageSva sva0
(
   .clk        (clk),
   .reset      (reset),
   .packetDone (packetDone),
   .running    (running),
   .byteStrobe (byteStrobe),
   .packetOut  (packetOut)
);

`default_nettype wire

//--- tb.sv
`timescale 1ns/10ps
`default_nettype none

module tb;

   import tsPkg::*;

   logic       clk;
   logic       reset;
   logic [7:0] inByte;
   logic       inValid;
   logic [7:0] outByte;
   logic       byteStrobe;
   logic       outValid;
   logic       packetOut;

   logic [7:0] payload [1:packetLen-1];   // bytes after the sync
   logic [7:0] rxQ [$];                   // bytes seen on the output
   logic [7:0] expQ [$];                  // bytes the model predicts
   bit         modelStage [1:15];         // prbs stages 1..15
   int         modelGroup;                // packet index in group of eight
   int         pktOutCount = 0;           // end of packet pulses seen
   int         valueErrors;
   int         timeoutErrors;

   tsTxTop dut0
   (
      .clk        (clk),
      .reset      (reset),
      .inByte     (inByte),
      .inValid    (inValid),
      .outByte    (outByte),
      .byteStrobe (byteStrobe),
      .outValid   (outValid),
      .packetOut  (packetOut)
   );

   initial
      clk = 1'b0;
   always #5 clk = ~clk;                  // 100 mhz sim clock

   // sample mid cycle, away from the edges
   always @(negedge clk)
   begin
      if (!reset && byteStrobe && outValid)
         rxQ.push_back(outByte);
      if (!reset && packetOut)
         pktOutCount++;
   end

   //////////////////////////////
   // reference model
   //////////////////////////////

   task automatic nextPrbsByte(output logic [7:0] bits);
      bit fb;
      for (int i = 7; i >= 0; i--)
      begin
         fb = modelStage[14] ^ modelStage[15];    // 1 + x^14 + x^15
         bits[i] = fb;                            // first bit lands in msb
         for (int k = 15; k > 1; k--)
            modelStage[k] = modelStage[k-1];
         modelStage[1] = fb;
      end
   endtask

   task automatic loadSeed;
      for (int k = 1; k <= 15; k++)
         modelStage[k] = prbsInit[15-k];          // leftmost seed bit is stage 1
   endtask

   task automatic modelPacket;
      logic [7:0] bits;
      if (modelGroup == 0)
      begin
         loadSeed();                              // period restart
         expQ.push_back(syncInv);
      end
      else
      begin
         expQ.push_back(syncByte);
         nextPrbsByte(bits);                      // sync slot still clocks 8 bits
      end
      modelGroup = (modelGroup + 1) % groupLen;
      for (int i = 1; i < packetLen; i++)
      begin
         nextPrbsByte(bits);
         expQ.push_back(payload[i] ^ bits);
      end
   endtask

   //////////////////////////////
   // stimulus helpers
   //////////////////////////////

   function automatic logic [7:0] nonSyncByte();
      logic [7:0] b;
      b = 8'($urandom);
      while (b == syncByte)
         b = 8'($urandom);
      return b;
   endfunction

   task automatic makePayload;
      for (int i = 1; i < packetLen; i++)
         payload[i] = nonSyncByte();
   endtask

   // one byte per 8 clocks, valid for a single cycle
   task automatic sendByte(input logic [7:0] b);
      @(posedge clk);
      #1;
      inByte  = b;
      inValid = 1'b1;
      @(posedge clk);
      #1;
      inValid = 1'b0;
      repeat (6) @(posedge clk);
   endtask

   task automatic sendPacket;
      modelPacket();
      sendByte(syncByte);
      for (int i = 1; i < packetLen; i++)
         sendByte(payload[i]);
   endtask

   task automatic resetDut;
      @(posedge clk);
      #1;
      reset      = 1'b1;
      modelGroup = 0;
      loadSeed();
      repeat (5)
      begin
         @(negedge clk);
         assert (!byteStrobe && !outValid && !packetOut) else
         begin
            valueErrors++;
            $display("FAIL %0t: output active during reset", $time);
         end
      end
      @(posedge clk);
      #1;
      reset = 1'b0;
   endtask

   task automatic waitEndOfPacket(input int target);
      int cycles;
      cycles = 0;
      while (pktOutCount < target && cycles < 4000)
      begin
         @(posedge clk);
         cycles++;
      end
      if (pktOutCount < target)
      begin
         timeoutErrors++;
         $display("timeout: only %0d of %0d end of packet pulses after %0d clocks",
                  pktOutCount, target, cycles);
      end
   endtask

   task automatic compareOutput(input string tag);
      assert (rxQ.size() == expQ.size()) else
      begin
         valueErrors++;
         $display("FAIL %0t: %s got %0d bytes, expected %0d",
                  $time, tag, rxQ.size(), expQ.size());
      end
      for (int i = 0; i < rxQ.size() && i < expQ.size(); i++)
      begin
         assert (rxQ[i] == expQ[i]) else
         begin
            valueErrors++;
            $display("FAIL %0t: %s byte %0d got %h expected %h",
                     $time, tag, i, rxQ[i], expQ[i]);
         end
      end
      rxQ.delete();
      expQ.delete();
   endtask

   //////////////////////////////
   // directed tests
   //////////////////////////////

   task automatic checkResetState;
      resetDut();
      @(negedge clk);
      assert (!byteStrobe) else
      begin
         valueErrors++;
         $display("FAIL %0t: byteStrobe high right after reset", $time);
      end
      repeat (100)
      begin
         @(negedge clk);
         assert (!outValid && !packetOut) else
         begin
            valueErrors++;
            $display("FAIL %0t: framing active with no input", $time);
         end
      end
      assert (rxQ.size() == 0) else
      begin
         valueErrors++;
         $display("FAIL %0t: %0d bytes appeared after reset", $time, rxQ.size());
      end
   endtask

   task automatic singlePacket;
      int base;
      base = pktOutCount;
      makePayload();
      sendPacket();
      waitEndOfPacket(base + 1);
      repeat (200) @(posedge clk);             // room for a stray second pulse
      assert (pktOutCount == base + 1) else
      begin
         valueErrors++;
         $display("FAIL %0t: %0d end of packet pulses, expected 1", $time, pktOutCount - base);
      end
      compareOutput("single packet");
   endtask

   task automatic groupOfEight;
      int base;
      resetDut();
      rxQ.delete();
      expQ.delete();
      base = pktOutCount;
      makePayload();                           // same payload for all nine
      for (int p = 0; p < 9; p++)
      begin
         sendPacket();
         repeat (40) @(posedge clk);           // lets the readout finish first
      end
      waitEndOfPacket(base + 9);
      if (rxQ.size() == 9 * packetLen)
      begin
         for (int p = 0; p < 9; p++)
         begin
            assert (rxQ[p*packetLen] == ((p % groupLen == 0) ? syncInv : syncByte)) else
            begin
               valueErrors++;
               $display("FAIL %0t: packet %0d sync %h", $time, p + 1, rxQ[p*packetLen]);
            end
         end
         for (int i = 1; i < packetLen; i++)
         begin
            assert (rxQ[8*packetLen+i] == rxQ[i]) else
            begin
               valueErrors++;
               $display("FAIL %0t: packet 9 byte %0d differs from packet 1", $time, i);
            end
         end
      end
      compareOutput("group of eight");
   endtask

   task automatic syncAlignment;
      int base;
      base = pktOutCount;
      for (int j = 0; j < 5; j++)
         sendByte(nonSyncByte());              // junk ahead of the sync
      makePayload();
      sendPacket();
      waitEndOfPacket(base + 1);
      compareOutput("alignment");
   endtask

   task automatic bankAlternation;
      int base;
      base = pktOutCount;
      for (int k = 0; k < 3; k++)
      begin
         makePayload();
         sendPacket();
         waitEndOfPacket(base + k + 1);
      end
      compareOutput("back to back banks");
   endtask

   initial
   begin
      reset         = 1'b1;
      inByte        = 8'h00;
      inValid       = 1'b0;
      valueErrors   = 0;
      timeoutErrors = 0;
      void'($urandom(88));

      checkResetState();
      singlePacket();
      groupOfEight();
      syncAlignment();
      bankAlternation();

      $display("errors: %0d value, %0d timeout", valueErrors, timeoutErrors);
      if (valueErrors == 0 && timeoutErrors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- tb.f
tsPkg.sv
packetWriter.sv
energyDispersal.sv
pingPongRam.sv
outStage.sv
tsTxTop.sv
tsTxTop_sva.sv
tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL CHECKS PASSED
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
